// ==== all.f ====
+incdir+rtl
rtl/aesPkg.sv
rtl/aesSbox.sv
rtl/aesKeyStep.sv
rtl/aesInitialRound.sv
rtl/aesRoundStage.sv
rtl/aesFinalRound.sv
rtl/aesEncryptTop.sv
verif/aesTb_sva.sv
verif/aesChecker.sv
verif/aesTb.sv

// ==== Bender.yml ====
package:
  name: aes_encrypt_pipe

export_include_dirs:
  - rtl

sources:
  - rtl/aesPkg.sv
  - rtl/aesSbox.sv
  - rtl/aesKeyStep.sv
  - rtl/aesInitialRound.sv
  - rtl/aesRoundStage.sv
  - rtl/aesFinalRound.sv
  - rtl/aesEncryptTop.sv
  - target: test
    files:
      - verif/aesTb_sva.sv
      - verif/aesChecker.sv
      - verif/aesTb.sv

// ==== verif/aesTb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "aes_cfg.svh"

module aesTb;

    localparam int TimeoutCycles = 200;

    logic              clk;
    logic              rst;
    logic              inValid;
    aesPkg::block_t    inBlock;
    aesPkg::roundKey_t inKey;
    logic              outValid;
    aesPkg::block_t    outBlock;
    int                errorCount;
    int                matchCount;
    int                pending;
    int                tbErrors;
    int                testCount;
    int                startErrors;
    logic [15:0]       lfsrState;

    aesEncryptTop i_dut (
        .clk(clk), .rst(rst), .inValid(inValid), .inBlock(inBlock), .inKey(inKey),
        .outValid(outValid), .outBlock(outBlock)
    );

    aesChecker iCheck (
        .clk(clk), .rst(rst), .inValid(inValid), .inBlock(inBlock), .inKey(inKey),
        .outValid(outValid), .outBlock(outBlock), .errorCount(errorCount),
        .matchCount(matchCount), .pending(pending)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // taps 16 14 13 11
    function automatic logic [15:0] lfsrNext(logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic drawBits(input int n, output logic [127:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsrState = lfsrNext(lfsrState);
            v = {v[126:0], lfsrState[0]};
        end
    endtask

    function automatic int totalErrors();
        return errorCount + tbErrors + i_dut.iSva.failCount;
    endfunction

    task automatic reportTest(input string name);
        testCount++;
        $display("test %0d %s: %0d errors", testCount, name, totalErrors() - startErrors);
        startErrors = totalErrors();
    endtask

    // enters and returns 2 ns after a rising edge
    task automatic sendBlock(input aesPkg::block_t b, input aesPkg::roundKey_t k);
        inValid = 1'b1;
        inBlock = b;
        inKey = k;
        @(posedge clk);
        #2;
        inValid = 1'b0;
    endtask

    task automatic sendRandom();
        logic [127:0] b;
        logic [127:0] k;
        drawBits(128, k);
        drawBits(128, b);
        sendBlock(b, k);
    endtask

    task automatic waitOutValid(output int cycles, output aesPkg::block_t blk);
        bit found;
        found = 1'b0;
        cycles = 0;
        while (!found && cycles < TimeoutCycles) begin
            @(posedge clk);
            cycles++;
            found = outValid;
            blk = outBlock;
        end
        if (!found) begin
            $display("timeout waiting for outValid");
            tbErrors++;
        end
        #2;
    endtask

    task automatic waitDrained();
        int cycles;
        cycles = 0;
        while (pending != 0 && cycles < TimeoutCycles) begin
            @(posedge clk);
            #2;
            cycles++;
        end
        if (pending != 0) begin
            $display("timeout with %0d results still pending", pending);
            tbErrors++;
        end
    endtask

    initial begin
        int cycles;
        int matchStart;
        int stale;
        aesPkg::block_t blk;
        logic [127:0] gap;
        rst = 1'b1;
        inValid = 1'b0;
        inBlock = '0;
        inKey = '0;
        tbErrors = 0;
        testCount = 0;
        startErrors = 0;
        lfsrState = 16'd4;
        repeat (3) @(posedge clk);
        #2;
        rst = 1'b0;

        sendBlock(128'h00112233445566778899aabbccddeeff, 128'h000102030405060708090a0b0c0d0e0f);
        waitOutValid(cycles, blk);
        if (blk !== 128'h69c4e0d86a7b0430d8cdb78070b4c55a) begin
            $display("FAILED outBlock expected %h got %h",
                     128'h69c4e0d86a7b0430d8cdb78070b4c55a, blk);
            tbErrors++;
        end
        waitDrained();
        reportTest("known vector");

        for (int i = 0; i < 40; i++) begin
            sendRandom();
        end
        waitDrained();
        reportTest("back-to-back random keys");

        for (int i = 0; i < 5; i++) begin
            sendRandom();
            waitOutValid(cycles, blk);
            if (cycles != `AES_LATENCY) begin
                $display("FAILED outValid latency expected %h got %h", `AES_LATENCY, cycles);
                tbErrors++;
            end
            waitDrained();
        end
        reportTest("isolated latency");

        matchStart = matchCount;
        for (int i = 0; i < 30; i++) begin
            drawBits(2, gap);
            for (int g = 0; g < gap; g++) begin
                @(posedge clk);
                #2;
            end
            sendRandom();
        end
        waitDrained();
        if (matchCount - matchStart != 30) begin
            $display("expected 30 results in order but got %0d", matchCount - matchStart);
            tbErrors++;
        end
        reportTest("random gaps");

        // reset with six blocks in flight
        for (int i = 0; i < 6; i++) begin
            sendRandom();
        end
        repeat (3) @(posedge clk);
        #2;
        rst = 1'b1;
        repeat (3) @(posedge clk);
        #2;
        rst = 1'b0;
        stale = 0;
        for (int c = 0; c < 2 * `AES_LATENCY; c++) begin
            @(posedge clk);
            stale += outValid;
        end
        #2;
        if (stale != 0) begin
            $display("outValid rose %0d times after reset with no new input", stale);
            tbErrors++;
        end
        matchStart = matchCount;
        for (int i = 0; i < 3; i++) begin
            sendRandom();
        end
        waitDrained();
        if (matchCount - matchStart != 3) begin
            $display("expected 3 results after reset but got %0d", matchCount - matchStart);
            tbErrors++;
        end
        reportTest("reset in flight");

        $display("%0d tests, %0d blocks matched, %0d errors", testCount, matchCount,
                 totalErrors());
        if (totalErrors() == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verif/aesChecker.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "aes_cfg.svh"

module aesChecker (
    input  logic              clk,
    input  logic              rst,
    input  logic              inValid,
    input  aesPkg::block_t    inBlock,
    input  aesPkg::roundKey_t inKey,
    input  logic              outValid,
    input  aesPkg::block_t    outBlock,
    output int                errorCount,
    output int                matchCount,
    output int                pending
);

    aesPkg::byte_t  sboxRef [256];
    aesPkg::block_t expQ [$];
    aesPkg::block_t expBlock;

    function automatic aesPkg::byte_t gfMul(aesPkg::byte_t a, aesPkg::byte_t b);
        aesPkg::byte_t p;
        aesPkg::byte_t x;
        p = 8'h00;
        x = a;
        for (int i = 0; i < 8; i++) begin
            if (b[i]) begin
                p = p ^ x;
            end
            x = {x[6:0], 1'b0} ^ (x[7] ? 8'h1b : 8'h00);
        end
        return p;
    endfunction

    // S-box from the field inverse and the affine map
    initial begin
        aesPkg::byte_t b;
        errorCount = 0;
        matchCount = 0;
        pending = 0;
        for (int v = 0; v < 256; v++) begin
            b = 8'h00;
            for (int c = 1; c < 256; c++) begin
                if (gfMul(v[7:0], c[7:0]) == 8'h01) begin
                    b = c[7:0];
                end
            end
            sboxRef[v] = b ^ {b[6:0], b[7]} ^ {b[5:0], b[7:6]} ^ {b[4:0], b[7:5]}
                         ^ {b[3:0], b[7:4]} ^ 8'h63;
        end
    end

    function automatic aesPkg::block_t aesRef(aesPkg::block_t pt, aesPkg::roundKey_t key);
        aesPkg::byte_t  st [16];
        aesPkg::byte_t  sh [16];
        aesPkg::word_t  w [44];
        aesPkg::word_t  t;
        aesPkg::byte_t  rc;
        aesPkg::block_t res;
        rc = 8'h01;
        for (int i = 0; i < 44; i++) begin
            if (i < 4) begin
                w[i] = key[127-32*i -: 32];
            end else begin
                t = w[i-1];
                if (i % 4 == 0) begin
                    t = {sboxRef[t[23:16]] ^ rc, sboxRef[t[15:8]], sboxRef[t[7:0]],
                         sboxRef[t[31:24]]};
                    rc = gfMul(rc, 8'h02);
                end
                w[i] = w[i-4] ^ t;
            end
        end
        for (int k = 0; k < 16; k++) begin
            st[k] = pt[127-8*k -: 8] ^ w[k/4][31-8*(k%4) -: 8];
        end
        for (int r = 1; r <= 10; r++) begin
            // substitution and row shift in one pass
            for (int k = 0; k < 16; k++) begin
                sh[k] = sboxRef[st[k%4 + 4*((k/4 + k%4) % 4)]];
            end
            for (int c = 0; c < 4; c++) begin
                for (int row = 0; row < 4; row++) begin
                    st[4*c+row] = sh[4*c+row];
                    if (r < 10) begin
                        st[4*c+row] = gfMul(sh[4*c+row], 8'h02)
                                      ^ gfMul(sh[4*c+(row+1)%4], 8'h03)
                                      ^ sh[4*c+(row+2)%4] ^ sh[4*c+(row+3)%4];
                    end
                    st[4*c+row] = st[4*c+row] ^ w[4*r+c][31-8*row -: 8];
                end
            end
        end
        for (int k = 0; k < 16; k++) begin
            res[127-8*k -: 8] = st[k];
        end
        return res;
    endfunction

    always @(posedge clk or posedge rst) begin
        if (rst) begin
            expQ.delete();
        end else begin
            if (inValid) begin
                expQ.push_back(aesRef(inBlock, inKey));
            end
            if (outValid && expQ.size() == 0) begin
                $display("outValid rose with no block pending at %0t", $time);
                errorCount++;
            end else if (outValid) begin
                expBlock = expQ.pop_front();
                if (outBlock !== expBlock) begin
                    $display("FAILED outBlock expected %h got %h", expBlock, outBlock);
                    errorCount++;
                end else begin
                    matchCount++;
                end
            end
        end
        pending = expQ.size();
    end

endmodule

`default_nettype wire

// ==== verif/aesTb_sva.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "aes_cfg.svh"

module aesTbSva (
    input logic clk,
    input logic rst,
    input logic inValid,
    input logic outValid
);

    int failCount = 0;
    logic [4:0] sinceReset;

    // cycles since reset release, saturating at the latency
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sinceReset <= '0;
        end else if (sinceReset < `AES_LATENCY) begin
            sinceReset <= sinceReset + 1'b1;
        end
    end

    aLatency: assert property (@(posedge clk) disable iff (rst)
        (sinceReset >= `AES_LATENCY) |-> (outValid == $past(inValid, `AES_LATENCY)))
    else begin
        failCount++;
        $error("outValid does not follow inValid by the pipeline latency");
    end

    aQuietAfterReset: assert property (@(posedge clk) disable iff (rst)
        (sinceReset < `AES_LATENCY) |-> !outValid)
    else begin
        failCount++;
        $error("outValid high too soon after reset");
    end

    aKnownValid: assert property (@(posedge clk) disable iff (rst) !$isunknown(outValid))
    else begin
        failCount++;
        $error("outValid is unknown");
    end

endmodule

bind aesEncryptTop aesTbSva iSva (
    .clk     (clk),
    .rst     (rst),
    .inValid (inValid),
    .outValid(outValid)
);

`default_nettype wire

// ==== rtl/aesEncryptTop.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "aes_cfg.svh"

module aesEncryptTop (
    input  logic              clk,
    input  logic              rst,
    input  logic              inValid,
    input  aesPkg::block_t    inBlock,
    input  aesPkg::roundKey_t inKey,
    output logic              outValid,
    output aesPkg::block_t    outBlock
);

    // link i feeds middle round i+1, the last link feeds the final round
    aesPkg::aesStage_t stageLink [`AES_ROUNDS];

    aesInitialRound iInitial (
        .clk     (clk),
        .rst     (rst),
        .inValid (inValid),
        .inBlock (inBlock),
        .inKey   (inKey),
        .stageOut(stageLink[0])
    );

    for (genvar r = 0; r < `AES_ROUNDS - 1; r++) begin : gRounds
        aesRoundStage iRound (
            .clk     (clk),
            .rst     (rst),
            .stageIn (stageLink[r]),
            .stageOut(stageLink[r+1])
        );
    end

    aesFinalRound iFinal (
        .clk     (clk),
        .rst     (rst),
        .stageIn (stageLink[`AES_ROUNDS-1]),
        .outValid(outValid),
        .outBlock(outBlock)
    );

endmodule

`default_nettype wire

// ==== rtl/aesFinalRound.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "aes_cfg.svh"

module aesFinalRound (
    input  logic              clk,
    input  logic              rst,
    input  aesPkg::aesStage_t stageIn,
    output logic              outValid,
    output aesPkg::block_t    outBlock
);

    aesPkg::roundKey_t lastKey;
    aesPkg::block_t    subState;
    aesPkg::block_t    shifted;

    // tenth round key, no rcon needed beyond it
    aesKeyStep iKeyStep (
        .key     (stageIn.key),
        .rcon    (stageIn.rcon),
        .nextKey (lastKey),
        .nextRcon()
    );

    for (genvar i = 0; i < aesPkg::NumBytes; i++) begin : gSubBytes
        aesSbox iSbox (
            .in (stageIn.state[`AES_BYTE_BITS*i +: `AES_BYTE_BITS]),
            .out(subState[`AES_BYTE_BITS*i +: `AES_BYTE_BITS])
        );
    end

    assign shifted = aesPkg::shiftRows(subState);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            outValid <= 1'b0;
        end else begin
            outValid <= stageIn.valid;
        end
    end

    // last round skips the column mix
    always_ff @(posedge clk) begin
        if (stageIn.valid) begin
            outBlock <= shifted ^ lastKey;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/aesRoundStage.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "aes_cfg.svh"

module aesRoundStage (
    input  logic              clk,
    input  logic              rst,
    input  aesPkg::aesStage_t stageIn,
    output aesPkg::aesStage_t stageOut
);

    aesPkg::roundKey_t roundKey;
    aesPkg::byte_t     nextRcon;
    aesPkg::block_t    subState;
    aesPkg::block_t    shifted;
    aesPkg::block_t    mixed;

    logic              validQ;
    aesPkg::block_t    stateQ;
    aesPkg::roundKey_t keyQ;
    aesPkg::byte_t     rconQ;

    // key for this round, derived from the previous one
    aesKeyStep iKeyStep (
        .key     (stageIn.key),
        .rcon    (stageIn.rcon),
        .nextKey (roundKey),
        .nextRcon(nextRcon)
    );

    for (genvar i = 0; i < aesPkg::NumBytes; i++) begin : gSubBytes
        aesSbox iSbox (
            .in (stageIn.state[`AES_BYTE_BITS*i +: `AES_BYTE_BITS]),
            .out(subState[`AES_BYTE_BITS*i +: `AES_BYTE_BITS])
        );
    end

    assign shifted = aesPkg::shiftRows(subState);

    for (genvar c = 0; c < 4; c++) begin : gMixColumns
        assign mixed[32*c +: 32] = aesPkg::mixColumn(shifted[32*c +: 32]);
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            validQ <= 1'b0;
        end else begin
            validQ <= stageIn.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (stageIn.valid) begin
            stateQ <= mixed ^ roundKey;
            keyQ   <= roundKey;
            rconQ  <= nextRcon;
        end
    end

    assign stageOut = '{valid: validQ, state: stateQ, key: keyQ, rcon: rconQ};

endmodule

`default_nettype wire

// ==== rtl/aesInitialRound.sv ====
`timescale 1ns/1ps
`default_nettype none

module aesInitialRound (
    input  logic              clk,
    input  logic              rst,
    input  logic              inValid,
    input  aesPkg::block_t    inBlock,
    input  aesPkg::roundKey_t inKey,
    output aesPkg::aesStage_t stageOut
);

    logic              validQ;
    aesPkg::block_t    stateQ;
    aesPkg::roundKey_t keyQ;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            validQ <= 1'b0;
        end else begin
            validQ <= inValid;
        end
    end

    // initial whitening with the cipher key
    always_ff @(posedge clk) begin
        if (inValid) begin
            stateQ <= inBlock ^ inKey;
            keyQ   <= inKey;
        end
    end

    // round 1 starts from rcon 01
    assign stageOut = '{valid: validQ, state: stateQ, key: keyQ, rcon: 8'h01};

endmodule

`default_nettype wire

// ==== rtl/aesKeyStep.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "aes_cfg.svh"

module aesKeyStep (
    input  aesPkg::roundKey_t key,
    input  aesPkg::byte_t     rcon,
    output aesPkg::roundKey_t nextKey,
    output aesPkg::byte_t     nextRcon
);

    aesPkg::word_t rotWord;
    aesPkg::word_t subWord;
    aesPkg::word_t tempWord;
    aesPkg::word_t w0;
    aesPkg::word_t w1;
    aesPkg::word_t w2;
    aesPkg::word_t w3;

    // RotWord on the last key word
    assign rotWord = {key[23:0], key[31:24]};

    for (genvar i = 0; i < 4; i++) begin : gSubWord
        aesSbox iSbox (
            .in (rotWord[`AES_BYTE_BITS*i +: `AES_BYTE_BITS]),
            .out(subWord[`AES_BYTE_BITS*i +: `AES_BYTE_BITS])
        );
    end

    assign tempWord = subWord ^ {rcon, 24'h000000};

    // xor chain across the four words
    assign w0 = key[127:96] ^ tempWord;
    assign w1 = key[95:64] ^ w0;
    assign w2 = key[63:32] ^ w1;
    assign w3 = key[31:0] ^ w2;

    assign nextKey  = {w0, w1, w2, w3};
    assign nextRcon = aesPkg::xtime(rcon);

endmodule

`default_nettype wire

// ==== rtl/aesSbox.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "aes_cfg.svh"

module aesSbox (
    input  logic [`AES_BYTE_BITS-1:0] in,
    output logic [`AES_BYTE_BITS-1:0] out
);

    // forward substitution table, entry 0 leftmost
    localparam logic [0:255][`AES_BYTE_BITS-1:0] SboxTable = {
        8'h63, 8'h7c, 8'h77, 8'h7b, 8'hf2, 8'h6b, 8'h6f, 8'hc5,
        8'h30, 8'h01, 8'h67, 8'h2b, 8'hfe, 8'hd7, 8'hab, 8'h76,
        8'hca, 8'h82, 8'hc9, 8'h7d, 8'hfa, 8'h59, 8'h47, 8'hf0,
        8'had, 8'hd4, 8'ha2, 8'haf, 8'h9c, 8'ha4, 8'h72, 8'hc0,
        8'hb7, 8'hfd, 8'h93, 8'h26, 8'h36, 8'h3f, 8'hf7, 8'hcc,
        8'h34, 8'ha5, 8'he5, 8'hf1, 8'h71, 8'hd8, 8'h31, 8'h15,
        8'h04, 8'hc7, 8'h23, 8'hc3, 8'h18, 8'h96, 8'h05, 8'h9a,
        8'h07, 8'h12, 8'h80, 8'he2, 8'heb, 8'h27, 8'hb2, 8'h75,
        8'h09, 8'h83, 8'h2c, 8'h1a, 8'h1b, 8'h6e, 8'h5a, 8'ha0,
        8'h52, 8'h3b, 8'hd6, 8'hb3, 8'h29, 8'he3, 8'h2f, 8'h84,
        8'h53, 8'hd1, 8'h00, 8'hed, 8'h20, 8'hfc, 8'hb1, 8'h5b,
        8'h6a, 8'hcb, 8'hbe, 8'h39, 8'h4a, 8'h4c, 8'h58, 8'hcf,
        8'hd0, 8'hef, 8'haa, 8'hfb, 8'h43, 8'h4d, 8'h33, 8'h85,
        8'h45, 8'hf9, 8'h02, 8'h7f, 8'h50, 8'h3c, 8'h9f, 8'ha8,
        8'h51, 8'ha3, 8'h40, 8'h8f, 8'h92, 8'h9d, 8'h38, 8'hf5,
        8'hbc, 8'hb6, 8'hda, 8'h21, 8'h10, 8'hff, 8'hf3, 8'hd2,
        8'hcd, 8'h0c, 8'h13, 8'hec, 8'h5f, 8'h97, 8'h44, 8'h17,
        8'hc4, 8'ha7, 8'h7e, 8'h3d, 8'h64, 8'h5d, 8'h19, 8'h73,
        8'h60, 8'h81, 8'h4f, 8'hdc, 8'h22, 8'h2a, 8'h90, 8'h88,
        8'h46, 8'hee, 8'hb8, 8'h14, 8'hde, 8'h5e, 8'h0b, 8'hdb,
        8'he0, 8'h32, 8'h3a, 8'h0a, 8'h49, 8'h06, 8'h24, 8'h5c,
        8'hc2, 8'hd3, 8'hac, 8'h62, 8'h91, 8'h95, 8'he4, 8'h79,
        8'he7, 8'hc8, 8'h37, 8'h6d, 8'h8d, 8'hd5, 8'h4e, 8'ha9,
        8'h6c, 8'h56, 8'hf4, 8'hea, 8'h65, 8'h7a, 8'hae, 8'h08,
        8'hba, 8'h78, 8'h25, 8'h2e, 8'h1c, 8'ha6, 8'hb4, 8'hc6,
        8'he8, 8'hdd, 8'h74, 8'h1f, 8'h4b, 8'hbd, 8'h8b, 8'h8a,
        8'h70, 8'h3e, 8'hb5, 8'h66, 8'h48, 8'h03, 8'hf6, 8'h0e,
        8'h61, 8'h35, 8'h57, 8'hb9, 8'h86, 8'hc1, 8'h1d, 8'h9e,
        8'he1, 8'hf8, 8'h98, 8'h11, 8'h69, 8'hd9, 8'h8e, 8'h94,
        8'h9b, 8'h1e, 8'h87, 8'he9, 8'hce, 8'h55, 8'h28, 8'hdf,
        8'h8c, 8'ha1, 8'h89, 8'h0d, 8'hbf, 8'he6, 8'h42, 8'h68,
        8'h41, 8'h99, 8'h2d, 8'h0f, 8'hb0, 8'h54, 8'hbb, 8'h16
    };

    assign out = SboxTable[in];

endmodule

`default_nettype wire

// ==== rtl/aesPkg.sv ====
`default_nettype none

`include "aes_cfg.svh"

package aesPkg;

    localparam int NumBytes = `AES_BLOCK_BITS / `AES_BYTE_BITS;

    typedef logic [`AES_BYTE_BITS-1:0] byte_t;
    typedef logic [4*`AES_BYTE_BITS-1:0] word_t;
    typedef logic [`AES_BLOCK_BITS-1:0] block_t;
    typedef logic [`AES_KEY_BITS-1:0] roundKey_t;

    // one pipeline slot, key schedule travels with the data
    typedef struct packed {
        logic      valid;
        block_t    state;
        roundKey_t key;
        byte_t     rcon;
    } aesStage_t;

    // multiply by x in GF(2^8)
    function automatic byte_t xtime(byte_t b);
        return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
    endfunction

    // byte k sits at row k%4, column k/4, first byte in the top bits
    function automatic block_t shiftRows(block_t s);
        block_t r;
        for (int col = 0; col < 4; col++) begin
            for (int row = 0; row < 4; row++) begin
                r[`AES_BLOCK_BITS-1-`AES_BYTE_BITS*(4*col+row) -: `AES_BYTE_BITS] =
                    s[`AES_BLOCK_BITS-1-`AES_BYTE_BITS*(4*((col+row)%4)+row) -: `AES_BYTE_BITS];
            end
        end
        return r;
    endfunction

    function automatic word_t mixColumn(word_t col);
        byte_t a0;
        byte_t a1;
        byte_t a2;
        byte_t a3;
        a0 = col[31:24];
        a1 = col[23:16];
        a2 = col[15:8];
        a3 = col[7:0];
        // 3*a written as xtime(a) ^ a
        return {xtime(a0) ^ xtime(a1) ^ a1 ^ a2 ^ a3,
                a0 ^ xtime(a1) ^ xtime(a2) ^ a2 ^ a3,
                a0 ^ a1 ^ xtime(a2) ^ xtime(a3) ^ a3,
                xtime(a0) ^ a0 ^ a1 ^ a2 ^ xtime(a3)};
    endfunction

endpackage

`default_nettype wire

// ==== rtl/aes_cfg.svh ====
`ifndef AES_CFG_SVH
`define AES_CFG_SVH

// state block and cipher key widths
`define AES_BLOCK_BITS 128
`define AES_KEY_BITS 128
`define AES_BYTE_BITS 8

// AES-128 round count
`define AES_ROUNDS 10

// entry stage plus one register per round
`define AES_LATENCY (`AES_ROUNDS + 1)

`endif
